// ==== sim.f ====
+incdir+source
source/heapTypesPkg.sv
source/heapOpsPkg.sv
source/heapRequestDecode.sv
source/arraySlot.sv
source/heapResultSelect.sv
source/heapMemory.sv
test/heapMemoryTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the heap testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module heapMemoryTb \
  -f sim.f -o heapMemorySim
./obj_dir/heapMemorySim | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "Simulation run succeeded"
else
  echo "Simulation run reported errors"
  exit 1
fi

// ==== test/heapMemoryTb.sv ====
//----------------------------------------------------------------------
// Testbench for the array heap with clock, reset, reference model,
// directed and random stimulus, and checking assertions
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "heapMemory_macros.svh"

module heapMemoryTb;
  import heapTypesPkg::*;
  import heapOpsPkg::*;

  logic        clock;
  logic        reset;
  heapAction   action;
  arrayId      array;
  elementIndex index;
  dataWord     in;
  dataWord     out;
  heapError    error;

  // Reference model state
  bit          modelFlag [`heapArrays];                      // Array allocated
  int          modelUsed;                                    // Numbers handed out
  int          modelStack [$];                               // Freed numbers in LIFO order
  int          modelSize [`heapArrays];
  dataWord     modelData [`heapArrays][`heapArrayLength];
  dataWord     modelOut;                                     // Out holds between results

  heapError    expErr;                                       // Expected for driven action
  dataWord     expOut;
  logic        checkValid;                                   // Result due at next edge
  heapError    checkErr;
  dataWord     checkOut;
  int          failCount;
  int          checkCount;
  int          testCount;
  int          testStartFails;
  int          testStartChecks;
  bit          timeoutSeen;

  heapMemory u_heapMemory (
    .clock(clock), .reset(reset),
    .action(action), .array(array), .index(index), .in(in),
    .out(out), .error(error)
  );

  always #2 clock = ~clock;                                  // 4 ns period

  //--------------------------------------------------------------------
  // Checking
  //--------------------------------------------------------------------
  always @(posedge clock) begin
    if (reset) begin
      checkValid <= 1'b0;
    end else begin
      checkValid <= (action != idle);                        // DUT registers at this edge
      checkErr   <= expErr;
      checkOut   <= expOut;
      if (checkValid)
        checkCount++;
    end
  end

  assert property (@(posedge clock) disable iff (reset) checkValid |-> error == checkErr)
    else begin
      $display("Fail error got %h expected %h", $sampled(error), $sampled(checkErr));
      failCount = failCount + 1;
    end

  assert property (@(posedge clock) disable iff (reset) checkValid |-> out == checkOut)
    else begin
      $display("Fail out got %h expected %h", $sampled(out), $sampled(checkOut));
      failCount = failCount + 1;
    end

  //--------------------------------------------------------------------
  // Reference model
  //--------------------------------------------------------------------
  task automatic clearAllocations();
    modelUsed = 0;
    modelStack.delete();
    foreach (modelFlag[i])
      modelFlag[i] = 1'b0;
  endtask

  task automatic predict(input heapAction act, input int arr, input int idx,
                         input dataWord din);
    heapError e;
    int       id;
    e  = errNone;
    id = 0;
    if (act == resetHeap) begin
      clearAllocations();
    end else if (act == alloc) begin
      if (modelStack.size() > 0) begin
        id = modelStack.pop_back();                          // Reuse latest free
      end else if (modelUsed < `heapArrays) begin
        id = modelUsed;
        modelUsed++;
      end else begin
        e = errOutOfMemory;
      end
      if (e == errNone) begin
        modelFlag[id] = 1'b1;
        modelSize[id] = 0;                                   // Size cleared and contents kept
        modelOut      = dataWord'(id);
      end
    end else if (act != idle) begin
      if (arr >= modelUsed)
        e = errNotAllocated;
      else if (!modelFlag[arr])
        e = errFreed;
      else if ((act == read || act == add || act == addAfter) && idx >= modelSize[arr])
        e = errOutOfBounds;
      else if (act == push && modelSize[arr] == `heapArrayLength)
        e = errFull;
      else if (act == pop && modelSize[arr] == 0)
        e = errEmpty;
      if (e == errNone) begin
        case (act)
          write: begin
            modelData[arr][idx] = din;
            if (idx >= modelSize[arr])
              modelSize[arr] = idx + 1;                      // Grows to cover index
            modelOut = din;
          end
          read:  modelOut = modelData[arr][idx];
          size:  modelOut = dataWord'(modelSize[arr]);
          push: begin
            modelData[arr][modelSize[arr]] = din;
            modelSize[arr]++;
          end
          pop: begin
            modelSize[arr]--;
            modelOut = modelData[arr][modelSize[arr]];
          end
          add: begin
            modelData[arr][idx] += din;                      // Wraps at 12 bits
            modelOut = modelData[arr][idx];
          end
          addAfter: begin
            modelOut = modelData[arr][idx];                  // Old value
            modelData[arr][idx] += din;
          end
          free: begin
            modelFlag[arr] = 1'b0;
            modelStack.push_back(arr);
          end
          default: begin
          end
        endcase
      end
    end
    expErr = e;
    expOut = modelOut;
  endtask

  //--------------------------------------------------------------------
  // Stimulus helpers
  //--------------------------------------------------------------------
  task automatic issue(input heapAction act, input int arr, input int idx,
                       input dataWord din);
    @(negedge clock);
    action = act;
    array  = arrayId'(arr);
    index  = elementIndex'(idx);
    in     = din;
    predict(act, arr, idx, din);
  endtask

  task automatic startTest();
    testStartFails  = failCount;
    testStartChecks = checkCount;
  endtask

  task automatic finishTest(input string name);
    int waited;
    @(negedge clock);
    action = idle;
    waited = 0;
    while (checkValid && waited < 20) begin                  // Last result still due
      @(negedge clock);
      waited++;
    end
    if (checkValid) begin
      $display("Timeout in test %s, a result was never checked", name);
      timeoutSeen = 1'b1;
    end
    testCount++;
    $display("Test %s done: %0d checks, %0d failures", name,
             checkCount - testStartChecks, failCount - testStartFails);
  endtask

  //--------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------
  task automatic allocTest();
    startTest();
    for (int n = 0; n < `heapArrays; n++)
      issue(alloc, 0, 0, '0);                                // Fresh numbers 0 up
    issue(alloc, 0, 0, '0);                                  // None left
    issue(free, 2, 0, '0);
    issue(free, 1, 0, '0);
    issue(alloc, 0, 0, '0);                                  // Gets 1 back
    issue(alloc, 0, 0, '0);                                  // Then 2
    finishTest("alloc");
  endtask

  task automatic writeReadTest();
    int      idx;
    dataWord word;
    startTest();
    for (int arr = 0; arr < 3; arr++) begin
      idx  = $urandom_range(`heapArrayLength - 2, 0);        // Leaves room past the end
      word = dataWord'($urandom);
      issue(write, arr, idx, word);
      issue(size, arr, 0, '0);
      issue(read, arr, idx, '0);
      issue(read, arr, idx + 1, '0);                         // Out of bounds
    end
    finishTest("writeRead");
  endtask

  task automatic stackTest();
    startTest();
    for (int n = 0; n <= `heapArrayLength; n++)
      issue(push, 3, 0, dataWord'($urandom));                // Last one hits full
    for (int n = 0; n <= `heapArrayLength; n++)
      issue(pop, 3, 0, '0);                                  // Last one hits empty
    finishTest("stack");
  endtask

  task automatic addTest();
    int idx;
    startTest();
    idx = $urandom_range(`heapArrayLength - 1, 0);
    issue(write, 0, idx, dataWord'($urandom));
    issue(add, 0, idx, 12'hF00 | dataWord'($urandom));       // Large addend that likely wraps
    issue(addAfter, 0, idx, dataWord'($urandom));
    issue(read, 0, idx, '0);
    issue(add, 3, 0, 12'h001);                               // Array 3 emptied by pops
    finishTest("add");
  endtask

  task automatic freeTest();
    startTest();
    issue(free, 3, 0, '0);
    issue(write, 3, 0, 12'h0AB);
    issue(read, 3, 0, '0);
    issue(push, 3, 0, 12'h0CD);
    issue(free, 3, 0, '0);                                   // Double free
    issue(resetHeap, 0, 0, '0);
    for (int arr = 0; arr < `heapArrays; arr++)
      issue(size, arr, 0, '0);                               // All unallocated now
    issue(alloc, 0, 0, '0);
    issue(read, 1, 0, '0);
    issue(size, 0, 0, '0);
    finishTest("free");
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------
  initial begin
    void'($urandom(32'h264d));
    clock       = 1'b0;
    reset       = 1'b1;
    action      = idle;
    array       = '0;
    index       = '0;
    in          = '0;
    expErr      = errNone;
    expOut      = '0;
    modelOut    = '0;
    failCount   = 0;
    checkCount  = 0;
    testCount   = 0;
    timeoutSeen = 1'b0;
    clearAllocations();
    foreach (modelSize[i])
      modelSize[i] = 0;
    for (int n = 0; n < 5; n++)
      @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    if (!timeoutSeen)
      allocTest();
    if (!timeoutSeen)
      writeReadTest();
    if (!timeoutSeen)
      stackTest();
    if (!timeoutSeen)
      addTest();
    if (!timeoutSeen)
      freeTest();

    $display("Tests %0d, checks %0d, failures %0d", testCount, checkCount, failCount);
    if (failCount == 0 && !timeoutSeen) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== source/heapMemory.sv ====
//----------------------------------------------------------------------
// Heap of fixed-length arrays built from the decoder, one slot per
// array and the result selector
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "heapMemory_macros.svh"

module heapMemory (
  input  logic                      clock,
  input  logic                      reset,
  input  heapOpsPkg::heapAction     action,           // Sampled every clock
  input  heapTypesPkg::arrayId      array,            // Array to work on
  input  heapTypesPkg::elementIndex index,            // Element within array
  input  heapTypesPkg::dataWord     in,               // Input word
  output heapTypesPkg::dataWord     out,              // Result, one clock later
  output heapOpsPkg::heapError      error             // Error, one clock later
);
  import heapTypesPkg::*;
  import heapOpsPkg::*;

  slotMask     slotSelect;                            // Decoder to slots
  slotCommand  command;
  elementIndex slotIndex;
  dataWord     slotData;
  arraySize    slotSizes    [`heapArrays];            // Slots to decoder
  dataWord     slotReadData [`heapArrays];            // Slots to selector
  arrayId      resultSource;                          // Decoder to selector
  arrayId      allocatedId;
  logic        takeSlotData;
  logic        takeAllocId;
  heapError    checkedError;

  heapRequestDecode u_decode (
    .clock(clock), .reset(reset),
    .action(action), .array(array), .index(index), .in(in),
    .sizes(slotSizes),
    .slotSelect(slotSelect), .command(command),
    .slotIndex(slotIndex), .slotData(slotData),
    .resultSource(resultSource), .allocatedId(allocatedId),
    .takeSlotData(takeSlotData), .takeAllocId(takeAllocId),
    .checkedError(checkedError)
  );

  // One slot per array
  for (genvar i = 0; i < `heapArrays; i++) begin : gSlot
    arraySlot u_slot (
      .clock(clock), .reset(reset),
      .selected(slotSelect[i]), .command(command),
      .index(slotIndex), .data(slotData),
      .size(slotSizes[i]), .readData(slotReadData[i])
    );
  end

  heapResultSelect u_select (
    .clock(clock), .reset(reset),
    .readData(slotReadData),
    .resultSource(resultSource), .allocatedId(allocatedId),
    .takeSlotData(takeSlotData), .takeAllocId(takeAllocId),
    .addNew(action == add), .addend(in),              // Add returns the sum
    .checkedError(checkedError),
    .out(out), .error(error)
  );

endmodule

// ==== source/heapResultSelect.sv ====
//----------------------------------------------------------------------
// Result selector that picks the addressed slot or the allocated
// number and registers out and error
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "heapMemory_macros.svh"

module heapResultSelect (
  input  logic                   clock,
  input  logic                   reset,
  input  heapTypesPkg::dataWord  readData [`heapArrays],  // Read port of each slot
  input  heapTypesPkg::arrayId   resultSource,            // Addressed slot
  input  heapTypesPkg::arrayId   allocatedId,             // Number from allocator
  input  logic                   takeSlotData,            // Load slot value
  input  logic                   takeAllocId,             // Load array number
  input  logic                   addNew,                  // Return sum, not old value
  input  heapTypesPkg::dataWord  addend,                  // Word added on add
  input  heapOpsPkg::heapError   checkedError,            // Error from decoder
  output heapTypesPkg::dataWord  out,                     // Registered result
  output heapOpsPkg::heapError   error                    // Registered error
);
  import heapTypesPkg::*;
  import heapOpsPkg::*;

  dataWord slotValue;                                     // Addressed slot's word

  assign slotValue = readData[resultSource] + (addNew ? addend : '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      out   <= '0;
      error <= errNone;
    end else begin
      error <= checkedError;                              // Every action reports
      if (takeAllocId)
        out <= dataWord'(allocatedId);
      else if (takeSlotData)
        out <= slotValue;                                 // Otherwise out holds
    end
  end

  // Decoder never sources out from two places
  assert property (@(posedge clock) disable iff (reset)
    !(takeSlotData && takeAllocId));

endmodule

// ==== source/arraySlot.sv ====
//----------------------------------------------------------------------
// One array of the heap with element storage, size counter, element
// update and the combinational read port
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "heapMemory_macros.svh"

module arraySlot (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      selected,        // This slot is addressed
  input  heapOpsPkg::slotCommand    command,         // Operation when selected
  input  heapTypesPkg::elementIndex index,           // Element to access
  input  heapTypesPkg::dataWord     data,            // Word to store or add
  output heapTypesPkg::arraySize    size,            // Current element count
  output heapTypesPkg::dataWord     readData         // Value before update
);
  import heapTypesPkg::*;
  import heapOpsPkg::*;

  dataWord     storage [`heapArrayLength];           // Element words
  elementIndex topIndex;                             // First free element
  elementIndex lastIndex;                            // Last used element
  logic        grows;                                // Write lands past the end

  assign topIndex  = size[`heapIndexBits-1:0];
  assign lastIndex = topIndex - 1'b1;
  assign grows     = arraySize'(index) >= size;

  //--------------------------------------------------------------------
  // Read port
  //--------------------------------------------------------------------
  always_comb begin
    if (!selected)
      readData = dataWord'(size);                    // Size query
    else if (command == slotPop)
      readData = storage[lastIndex];                 // Element being removed
    else if (command == slotWrite)
      readData = data;                               // Echo the stored word
    else
      readData = storage[index];                     // Read, add, addAfter
  end

  //--------------------------------------------------------------------
  // Storage
  //--------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (selected) begin
      case (command)
        slotWrite: storage[index]    <= data;
        slotPush:  storage[topIndex] <= data;        // Append
        slotAdd:   storage[index]    <= storage[index] + data;  // Wraps at data width
        default: begin
        end
      endcase
    end
  end

  // Size counter
  always_ff @(posedge clock) begin
    if (reset) begin
      size <= '0;
    end else if (selected) begin
      case (command)
        slotClear: size <= '0;
        slotWrite: begin
          if (grows)
            size <= arraySize'(index) + 1'b1;        // Extend to cover index
        end
        slotPush:  size <= size + 1'b1;
        slotPop:   size <= size - 1'b1;
        default: begin
        end
      endcase
    end
  end

  // Decoder refuses pushes on a full array
  assert property (@(posedge clock) disable iff (reset)
    size <= arraySize'(`heapArrayLength));

endmodule

// ==== source/heapRequestDecode.sv ====
//----------------------------------------------------------------------
// Request decoder with allocation flags, free stack, action checks
// and the command issued to the addressed array slot
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "heapMemory_macros.svh"

module heapRequestDecode (
  input  logic                     clock,
  input  logic                     reset,
  input  heapOpsPkg::heapAction    action,                   // Requested action
  input  heapTypesPkg::arrayId     array,                    // Target array
  input  heapTypesPkg::elementIndex index,                   // Target element
  input  heapTypesPkg::dataWord    in,                       // Input word
  input  heapTypesPkg::arraySize   sizes [`heapArrays],      // Size of each slot
  output heapTypesPkg::slotMask    slotSelect,               // One-hot or zero
  output heapOpsPkg::slotCommand   command,                  // Command for selected slot
  output heapTypesPkg::elementIndex slotIndex,               // Index to all slots
  output heapTypesPkg::dataWord    slotData,                 // Data to all slots
  output heapTypesPkg::arrayId     resultSource,             // Slot that feeds out
  output heapTypesPkg::arrayId     allocatedId,              // Number chosen by alloc
  output logic                     takeSlotData,             // Out comes from a slot
  output logic                     takeAllocId,              // Out comes from allocator
  output heapOpsPkg::heapError     checkedError              // Error of this action
);
  import heapTypesPkg::*;
  import heapOpsPkg::*;

  //--------------------------------------------------------------------
  // Allocation state
  //--------------------------------------------------------------------
  slotMask                    allocFlags;                    // Array currently allocated
  logic [`heapArrayIdBits:0]  usedCount;                     // Numbers handed out so far
  logic [`heapArrayIdBits:0]  freeTop;                       // Free stack depth
  logic [`heapArrayIdBits:0]  topIndex;                      // Entry below top
  arrayId                     freeStack [`heapArrays];       // LIFO of freed numbers
  logic                       allocOk;                       // Alloc can succeed
  logic                       passed;                        // Free passed its checks
  arraySize                   targetSize;                    // Size of addressed array
  logic                       inRange;                       // Index below size

  assign topIndex     = freeTop - 1'b1;
  assign slotIndex    = index;                               // Passed through
  assign slotData     = in;
  assign resultSource = array;
  assign targetSize   = sizes[array];
  assign inRange      = arraySize'(index) < targetSize;
  assign passed       = (action == free) && (checkedError == errNone);

  // Alloc reuses the latest freed number before a fresh one
  always_comb begin
    allocOk     = 1'b0;
    allocatedId = '0;
    if (freeTop != '0) begin
      allocOk     = 1'b1;
      allocatedId = freeStack[topIndex[`heapArrayIdBits-1:0]];  // Most recently freed
    end else if (usedCount < (`heapArrayIdBits+1)'(`heapArrays)) begin
      allocOk     = 1'b1;
      allocatedId = usedCount[`heapArrayIdBits-1:0];         // Next never-used
    end
  end

  //--------------------------------------------------------------------
  // Checks and slot command
  //--------------------------------------------------------------------
  always_comb begin
    slotSelect   = '0;
    command      = slotIdle;
    takeSlotData = 1'b0;
    takeAllocId  = 1'b0;
    checkedError = errNone;
    if (action == alloc) begin
      if (allocOk) begin
        slotSelect[allocatedId] = 1'b1;                      // Fresh array starts empty
        command                 = slotClear;
        takeAllocId             = 1'b1;
      end else begin
        checkedError = errOutOfMemory;
      end
    end else if (action != idle && action != resetHeap) begin
      if ({1'b0, array} >= usedCount)
        checkedError = errNotAllocated;
      else if (!allocFlags[array])
        checkedError = errFreed;
      else if ((action == read || action == add || action == addAfter) && !inRange)
        checkedError = errOutOfBounds;
      else if (action == push && targetSize == arraySize'(`heapArrayLength))
        checkedError = errFull;
      else if (action == pop && targetSize == '0)
        checkedError = errEmpty;

      if (checkedError == errNone) begin
        case (action)
          write: begin
            slotSelect[array] = 1'b1;
            command           = slotWrite;
            takeSlotData      = 1'b1;                        // Echo written word
          end
          read: begin
            slotSelect[array] = 1'b1;                        // Selected slot shows element
            takeSlotData      = 1'b1;
          end
          size: begin
            takeSlotData = 1'b1;                             // Unselected slot shows size
          end
          push: begin
            slotSelect[array] = 1'b1;
            command           = slotPush;                    // Nothing returned
          end
          pop: begin
            slotSelect[array] = 1'b1;
            command           = slotPop;
            takeSlotData      = 1'b1;
          end
          add, addAfter: begin
            slotSelect[array] = 1'b1;
            command           = slotAdd;
            takeSlotData      = 1'b1;                        // Selector picks old or new
          end
          default: begin
          end
        endcase
      end
    end
  end

  //--------------------------------------------------------------------
  // Allocation state update
  //--------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (reset || action == resetHeap) begin
      allocFlags <= '0;
      usedCount  <= '0;
      freeTop    <= '0;
    end else if (action == alloc && allocOk) begin
      allocFlags[allocatedId] <= 1'b1;
      if (freeTop != '0)
        freeTop <= topIndex;                                 // Pop free stack
      else
        usedCount <= usedCount + 1'b1;
    end else if (passed) begin
      allocFlags[array] <= 1'b0;
      freeTop           <= freeTop + 1'b1;                   // Push free stack
    end
  end

  always_ff @(posedge clock) begin
    if (passed)
      freeStack[freeTop[`heapArrayIdBits-1:0]] <= array;     // Stack payload
  end

  // Double frees are refused, so the stack holds each array at most once
  assert property (@(posedge clock) disable iff (reset)
    freeTop <= (`heapArrayIdBits+1)'(`heapArrays));

endmodule

// ==== source/heapOpsPkg.sv ====
//----------------------------------------------------------------------
// Heap action codes, commands sent to array slots and error kinds
//----------------------------------------------------------------------
package heapOpsPkg;

  //--------------------------------------------------------------------
  // Actions accepted at the top level
  //--------------------------------------------------------------------
  typedef enum logic [7:0] {
    idle      = 8'd0,                 // Nothing to do
    resetHeap = 8'd1,                 // Drop all allocations
    write     = 8'd2,                 // Write an element
    read      = 8'd3,                 // Read an element
    size      = 8'd4,                 // Size of an array
    push      = 8'd14,                // Push onto the end
    pop       = 8'd15,                // Pop from the end
    alloc     = 8'd18,                // Allocate an array
    free      = 8'd19,                // Free an array for reuse
    add       = 8'd20,                // Add and return new value
    addAfter  = 8'd21                 // Add and return old value
  } heapAction;

  //--------------------------------------------------------------------
  // Commands from the decoder to one slot
  //--------------------------------------------------------------------
  typedef enum logic [2:0] {
    slotIdle  = 3'd0,                 // Hold storage and size
    slotClear = 3'd1,                 // Empty the array
    slotWrite = 3'd2,                 // Store at index
    slotPush  = 3'd3,                 // Store at size and grow
    slotPop   = 3'd4,                 // Shrink by one
    slotAdd   = 3'd5                  // Accumulate into element
  } slotCommand;

  //--------------------------------------------------------------------
  // Error kinds reported with each result
  //--------------------------------------------------------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,           // Action completed
    errNotAllocated = 3'd1,           // Number never handed out
    errFreed        = 3'd2,           // Array was freed
    errOutOfBounds  = 3'd3,           // Index at or past size
    errFull         = 3'd4,           // Push on full array
    errEmpty        = 3'd5,           // Pop on empty array
    errOutOfMemory  = 3'd6            // No array left to allocate
  } heapError;

endpackage

// ==== source/heapTypesPkg.sv ====
//----------------------------------------------------------------------
// Vector types for array numbers, element indexes, array sizes,
// element values and per-array masks
//----------------------------------------------------------------------
`include "heapMemory_macros.svh"

package heapTypesPkg;

  // Addressing
  typedef logic [`heapArrayIdBits-1:0] arrayId;       // Number of an array
  typedef logic [`heapIndexBits-1:0]   elementIndex;  // Index within an array

  // One bit wider than an index so a full array fits
  typedef logic [`heapIndexBits:0]     arraySize;     // Element count

  // Payload
  typedef logic [`heapDataBits-1:0]    dataWord;      // Element value

  // One bit per array
  typedef logic [`heapArrays-1:0]      slotMask;      // Slot select or flags

endpackage

// ==== source/heapMemory_macros.svh ====
//----------------------------------------------------------------------
// Widths of array numbers, element indexes and elements, and the
// number and length of the arrays in the heap
//----------------------------------------------------------------------
`ifndef HEAP_MEMORY_MACROS_SVH
`define HEAP_MEMORY_MACROS_SVH

// Field widths
`define heapArrayIdBits  2          // Bits in an array number
`define heapIndexBits    3          // Bits in an element index
`define heapDataBits     12         // Bits in one element

// Heap geometry
`define heapArrays       4          // Arrays in the heap
`define heapArrayLength  8          // Elements per array

`endif
